/* compile.f */
src/soc_bus_pkg.sv
src/soc_perip_pkg.sv
src/bus_arbiter.sv
src/apb_bridge.sv
src/gpio_regs.sv
src/timer_unit.sv
src/irq_ctrl.sv
src/periph_subsys_top.sv
verification/periph_subsys_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the peripheral subsystem testbench with Verilator and runs it.
# Exits non-zero unless the simulation prints the pass message.

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator was not found on PATH"
    exit 1
fi

verilator --binary --timing --assert -Wno-fatal \
    -f compile.f --top-module periph_subsys_tb -o periph_subsys_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/periph_subsys_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "Test passed"; then
    exit 0
fi
exit 1

/* src/apb_bridge.sv */
// Turns one started request into an APB setup and access phase
// Finish and response are combinational in the access cycle
// Unmapped addresses run the same phases with no psel and come back as errors
`timescale 1ns/10ps

module apb_bridge import soc_bus_pkg::*, soc_perip_pkg::*; (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic               start_i,
    input  bus_req_t           req_i,
    output logic               finish_o,
    output bus_rsp_t           rsp_o,
    output apb_req_t           apb_o,
    output logic [NUM_SLV-1:0] psel_o,
    input  apb_rsp_t           apb_rsp_i [NUM_SLV]
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SETUP,
        ST_ACCESS
    } state_t;

    state_t                      state_q;
    bus_req_t                    req_q;
    logic [SLV_IDX_W-1:0]        slv_q;
    logic                        mapped_q;
    logic [ADDR_W-SLV_LSB-1:0]   slv_field;

    assign slv_field = req_i.addr[ADDR_W-1:SLV_LSB];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= ST_IDLE;
        end else begin
            case (state_q)
                ST_IDLE:   if (start_i) state_q <= ST_SETUP;
                ST_SETUP:  state_q <= ST_ACCESS;
                default:   state_q <= ST_IDLE;    // Zero wait states
            endcase
        end
    end

    // Request and decode latched once per access
    always_ff @(posedge clk_i) begin
        if (state_q == ST_IDLE && start_i) begin
            req_q    <= req_i;
            slv_q    <= slv_field[SLV_IDX_W-1:0];
            mapped_q <= (slv_field < NUM_SLV);
        end
    end

    always_comb begin
        psel_o = '0;
        if (state_q != ST_IDLE && mapped_q) begin
            psel_o[slv_q] = 1'b1;
        end
    end

    assign apb_o.paddr   = req_q.addr;
    assign apb_o.pwrite  = req_q.write;
    assign apb_o.pwdata  = req_q.wdata;
    assign apb_o.penable = (state_q == ST_ACCESS) && mapped_q;

    assign finish_o = (state_q == ST_ACCESS);

    always_comb begin
        rsp_o = '0;
        if (state_q == ST_ACCESS) begin
            if (mapped_q) begin
                rsp_o.rdata = apb_rsp_i[slv_q].prdata;
                rsp_o.err   = apb_rsp_i[slv_q].pslverr;
            end else begin
                rsp_o.err = 1'b1;                 // Nothing answers here
            end
        end
    end

    // Access phase follows a setup phase to the same slave
    a_penable_after_setup: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        apb_o.penable |-> (|psel_o) && $past(psel_o) == psel_o && !$past(apb_o.penable));

    // One slave selected for exactly the setup and access cycles
    a_psel_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $rose(|psel_o) |-> $onehot(psel_o) ##1 $stable(psel_o) ##1 (psel_o == '0));

endmodule

/* src/bus_arbiter.sv */
// Round-robin arbiter for two hosts in front of one bridge
// Hosts hold valid and request until their done pulse
// Only one access is in flight, a losing host simply sees a late done
`timescale 1ns/10ps

module bus_arbiter import soc_bus_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  logic     host0_valid_i,
    input  logic     host1_valid_i,
    input  bus_req_t host0_req_i,
    input  bus_req_t host1_req_i,
    output logic     host0_done_o,
    output logic     host1_done_o,
    output bus_rsp_t host0_rsp_o,
    output bus_rsp_t host1_rsp_o,
    output logic     start_o,
    output bus_req_t req_o,
    input  logic     finish_i,
    input  bus_rsp_t rsp_i
);

    logic       busy_q;
    logic       start_q;
    logic [1:0] grant_q;
    logic       rr_ptr_q;   // High favours host 1
    logic       pick_1;

    // Host 1 wins when alone or when the pointer favours it
    assign pick_1 = host1_valid_i && (!host0_valid_i || rr_ptr_q);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q   <= 1'b0;
            start_q  <= 1'b0;
            grant_q  <= 2'b00;
            rr_ptr_q <= 1'b0;
        end else begin
            start_q <= 1'b0;
            if (!busy_q) begin
                if (host0_valid_i || host1_valid_i) begin
                    busy_q   <= 1'b1;
                    start_q  <= 1'b1;
                    grant_q  <= pick_1 ? 2'b10 : 2'b01;
                    rr_ptr_q <= !pick_1;          // Next tie goes to the other host
                end
            end else if (finish_i) begin
                busy_q  <= 1'b0;
                grant_q <= 2'b00;
            end
        end
    end

    assign start_o = start_q;
    assign req_o   = grant_q[1] ? host1_req_i : host0_req_i;

    assign host0_done_o = finish_i && grant_q[0];
    assign host1_done_o = finish_i && grant_q[1];
    assign host0_rsp_o  = grant_q[0] ? rsp_i : '0;
    assign host1_rsp_o  = grant_q[1] ? rsp_i : '0;

    // Each start carries a one-hot grant to a host that is still asking
    a_grant_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        start_q |-> $onehot(grant_q) && |(grant_q & {host1_valid_i, host0_valid_i}));

    // Grant stays put for the whole bridge access, finish comes two cycles after start
    a_grant_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        start_q |=> ($stable(grant_q) && !finish_i) ##1 ($stable(grant_q) && finish_i));

endmodule

/* src/gpio_regs.sv */
// GPIO block with output, direction and interrupt enable registers
// Pins pass a two-flop synchroniser, rising edges latch into GPIO_IS
// Event output is a level while any enabled status bit is set
`timescale 1ns/10ps

module gpio_regs import soc_bus_pkg::*, soc_perip_pkg::*; #(
    parameter int GPIO_WIDTH = 8
) (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  apb_req_t              apb_i,
    input  logic                  psel_i,
    output apb_rsp_t              apb_rsp_o,
    input  logic [GPIO_WIDTH-1:0] gpio_in_i,
    output logic [GPIO_WIDTH-1:0] gpio_out_o,
    output logic [GPIO_WIDTH-1:0] gpio_dir_o,
    output logic                  gpio_event_o
);

    logic [GPIO_WIDTH-1:0] out_q, dir_q, ie_q, is_q;
    logic [GPIO_WIDTH-1:0] sync1_q, sync2_q, prev_q;
    logic [GPIO_WIDTH-1:0] rise, is_clr;
    logic [OFFS_W-1:0]     offs;
    logic                  wr_en;

    assign offs   = apb_i.paddr[OFFS_W-1:0];
    assign wr_en  = psel_i && apb_i.penable && apb_i.pwrite;
    assign rise   = sync2_q & ~prev_q;
    assign is_clr = (wr_en && offs == GPIO_IS) ? apb_i.pwdata[GPIO_WIDTH-1:0] : '0;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            out_q   <= '0;
            dir_q   <= '0;
            ie_q    <= '0;
            is_q    <= '0;
            sync1_q <= '0;
            sync2_q <= '0;
            prev_q  <= '0;
        end else begin
            sync1_q <= gpio_in_i;
            sync2_q <= sync1_q;
            prev_q  <= sync2_q;
            is_q    <= (is_q & ~is_clr) | rise;     // New edge beats the clear
            if (wr_en && offs == GPIO_OUT) out_q <= apb_i.pwdata[GPIO_WIDTH-1:0];
            if (wr_en && offs == GPIO_DIR) dir_q <= apb_i.pwdata[GPIO_WIDTH-1:0];
            if (wr_en && offs == GPIO_IE)  ie_q  <= apb_i.pwdata[GPIO_WIDTH-1:0];
        end
    end

    always_comb begin
        apb_rsp_o = '0;
        case (offs)
            GPIO_OUT: apb_rsp_o.prdata = DATA_W'(out_q);
            GPIO_DIR: apb_rsp_o.prdata = DATA_W'(dir_q);
            GPIO_IN:  apb_rsp_o.prdata = DATA_W'(sync2_q);
            GPIO_IE:  apb_rsp_o.prdata = DATA_W'(ie_q);
            GPIO_IS:  apb_rsp_o.prdata = DATA_W'(is_q);
            default:  apb_rsp_o.pslverr = psel_i;   // Hole in the map
        endcase
    end

    assign gpio_out_o   = out_q;
    assign gpio_dir_o   = dir_q;
    assign gpio_event_o = |(is_q & ie_q);

endmodule

/* src/irq_ctrl.sv */
// Interrupt controller with pending and enable bits per source
// A source held high keeps its pending bit set despite a clear
// irq_o is registered and trails the pending state by one cycle
`timescale 1ns/10ps

module irq_ctrl import soc_bus_pkg::*, soc_perip_pkg::*; (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  apb_req_t           apb_i,
    input  logic               psel_i,
    output apb_rsp_t           apb_rsp_o,
    input  logic [NUM_IRQ-1:0] irq_src_i,
    output logic               irq_o
);

    logic [NUM_IRQ-1:0] pend_q, en_q, pend_clr;
    logic               irq_q;
    logic [OFFS_W-1:0]  offs;
    logic               wr_en;

    assign offs     = apb_i.paddr[OFFS_W-1:0];
    assign wr_en    = psel_i && apb_i.penable && apb_i.pwrite;
    assign pend_clr = (wr_en && offs == IRQ_PEND) ? apb_i.pwdata[NUM_IRQ-1:0] : '0;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pend_q <= '0;
            en_q   <= '0;
            irq_q  <= 1'b0;
        end else begin
            pend_q <= (pend_q & ~pend_clr) | irq_src_i;
            if (wr_en && offs == IRQ_EN) en_q <= apb_i.pwdata[NUM_IRQ-1:0];
            irq_q  <= |(pend_q & en_q);
        end
    end

    always_comb begin
        apb_rsp_o = '0;
        case (offs)
            IRQ_PEND: apb_rsp_o.prdata = DATA_W'(pend_q);
            IRQ_EN:   apb_rsp_o.prdata = DATA_W'(en_q);
            default:  apb_rsp_o.pslverr = psel_i;
        endcase
    end

    assign irq_o = irq_q;

endmodule

/* src/periph_subsys_top.sv */
// Peripheral subsystem with two bus hosts sharing one APB bus
// Single clock, asynchronous active-low reset, zero wait-state slaves
// Interrupt sources are GPIO, timer and one external event pin
`timescale 1ns/10ps

module periph_subsys_top import soc_bus_pkg::*, soc_perip_pkg::*; #(
    parameter int GPIO_WIDTH  = 8,
    parameter int TIMER_WIDTH = 16
) (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  host0_valid_i,
    input  bus_req_t              host0_req_i,
    output logic                  host0_done_o,
    output bus_rsp_t              host0_rsp_o,
    input  logic                  host1_valid_i,
    input  bus_req_t              host1_req_i,
    output logic                  host1_done_o,
    output bus_rsp_t              host1_rsp_o,
    input  logic [GPIO_WIDTH-1:0] gpio_in_i,
    output logic [GPIO_WIDTH-1:0] gpio_out_o,
    output logic [GPIO_WIDTH-1:0] gpio_dir_o,
    output logic                  timer_o,
    input  logic                  ext_evt_i,
    output logic                  irq_o
);

    logic               start, finish;
    bus_req_t           arb_req;
    bus_rsp_t           arb_rsp;
    apb_req_t           apb;
    logic [NUM_SLV-1:0] psel;
    apb_rsp_t           slv_rsp [NUM_SLV];
    logic               gpio_evt, timer_evt;
    logic [NUM_IRQ-1:0] irq_src;

    assign irq_src[IRQ_GPIO]  = gpio_evt;
    assign irq_src[IRQ_TIMER] = timer_evt;
    assign irq_src[IRQ_EXT]   = ext_evt_i;

    bus_arbiter u_bus_arbiter (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .host0_valid_i(host0_valid_i),
        .host1_valid_i(host1_valid_i),
        .host0_req_i  (host0_req_i),
        .host1_req_i  (host1_req_i),
        .host0_done_o (host0_done_o),
        .host1_done_o (host1_done_o),
        .host0_rsp_o  (host0_rsp_o),
        .host1_rsp_o  (host1_rsp_o),
        .start_o      (start),
        .req_o        (arb_req),
        .finish_i     (finish),
        .rsp_i        (arb_rsp)
    );

    apb_bridge u_apb_bridge (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .start_i  (start),
        .req_i    (arb_req),
        .finish_o (finish),
        .rsp_o    (arb_rsp),
        .apb_o    (apb),
        .psel_o   (psel),
        .apb_rsp_i(slv_rsp)
    );

    gpio_regs #(
        .GPIO_WIDTH(GPIO_WIDTH)
    ) u_gpio_regs (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .apb_i       (apb),
        .psel_i      (psel[SLV_GPIO]),
        .apb_rsp_o   (slv_rsp[SLV_GPIO]),
        .gpio_in_i   (gpio_in_i),
        .gpio_out_o  (gpio_out_o),
        .gpio_dir_o  (gpio_dir_o),
        .gpio_event_o(gpio_evt)
    );

    timer_unit #(
        .TIMER_WIDTH(TIMER_WIDTH)
    ) u_timer_unit (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .apb_i        (apb),
        .psel_i       (psel[SLV_TIMER]),
        .apb_rsp_o    (slv_rsp[SLV_TIMER]),
        .timer_o      (timer_o),
        .timer_event_o(timer_evt)
    );

    irq_ctrl u_irq_ctrl (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .apb_i    (apb),
        .psel_i   (psel[SLV_IRQ]),
        .apb_rsp_o(slv_rsp[SLV_IRQ]),
        .irq_src_i(irq_src),
        .irq_o    (irq_o)
    );

endmodule

/* src/soc_bus_pkg.sv */
// Shared bus widths and the packed payloads between hosts, arbiter, bridge and slaves
// Single clock domain, full-word accesses only with no byte strobes
// Slaves always answer in the access phase, so there is no pready field
package soc_bus_pkg;

    localparam int ADDR_W = 12;
    localparam int DATA_W = 32;

    // Host side request, held stable until done
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic              write;
        logic [DATA_W-1:0] wdata;
    } bus_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] rdata;
        logic              err;    // Slave error or unmapped address
    } bus_rsp_t;

    // Outgoing APB fields common to all slaves, psel travels separately
    typedef struct packed {
        logic [ADDR_W-1:0] paddr;
        logic              pwrite;
        logic [DATA_W-1:0] pwdata;
        logic              penable;
    } apb_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] prdata;
        logic              pslverr;
    } apb_rsp_t;

endpackage

/* src/soc_perip_pkg.sv */
// Peripheral address map, register offsets and interrupt numbering
// Address bits 11..8 pick the slave, slave field values 3 and up are unmapped
// Slaves decode only the low byte of the address
package soc_perip_pkg;

    localparam int NUM_SLV   = 3;
    localparam int SLV_IDX_W = 2;
    localparam int SLV_LSB   = 8;     // Lowest bit of the slave field
    localparam int OFFS_W    = 8;     // Register offset width inside a slave

    localparam int SLV_GPIO  = 0;
    localparam int SLV_TIMER = 1;
    localparam int SLV_IRQ   = 2;

    // GPIO registers
    localparam logic [OFFS_W-1:0] GPIO_OUT = 8'h00;
    localparam logic [OFFS_W-1:0] GPIO_DIR = 8'h04;
    localparam logic [OFFS_W-1:0] GPIO_IN  = 8'h08;   // Read only
    localparam logic [OFFS_W-1:0] GPIO_IE  = 8'h0C;
    localparam logic [OFFS_W-1:0] GPIO_IS  = 8'h10;   // Write one to clear

    // Timer registers
    localparam logic [OFFS_W-1:0] TMR_CTRL = 8'h00;   // Bit 0 enables counting
    localparam logic [OFFS_W-1:0] TMR_CMP  = 8'h04;
    localparam logic [OFFS_W-1:0] TMR_CNT  = 8'h08;   // Read only

    // Interrupt controller registers
    localparam logic [OFFS_W-1:0] IRQ_PEND = 8'h00;   // Write one to clear
    localparam logic [OFFS_W-1:0] IRQ_EN   = 8'h04;

    localparam int IRQ_GPIO  = 0;
    localparam int IRQ_TIMER = 1;
    localparam int IRQ_EXT   = 2;
    localparam int NUM_IRQ   = 3;

endpackage

/* src/timer_unit.sv */
// Compare-match timer counting one step per clock while enabled
// On match it pulses the event, flips the channel and restarts from zero
// Writing the compare value also restarts the count
`timescale 1ns/10ps

module timer_unit import soc_bus_pkg::*, soc_perip_pkg::*; #(
    parameter int TIMER_WIDTH = 16
) (
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  apb_req_t apb_i,
    input  logic     psel_i,
    output apb_rsp_t apb_rsp_o,
    output logic     timer_o,
    output logic     timer_event_o
);

    logic                   en_q;
    logic [TIMER_WIDTH-1:0] cmp_q;
    logic [TIMER_WIDTH-1:0] cnt_q;
    logic                   tgl_q;
    logic [OFFS_W-1:0]      offs;
    logic                   wr_en;
    logic                   cmp_wr;

    assign offs   = apb_i.paddr[OFFS_W-1:0];
    assign wr_en  = psel_i && apb_i.penable && apb_i.pwrite;
    assign cmp_wr = wr_en && offs == TMR_CMP;

    assign timer_event_o = en_q && (cnt_q == cmp_q);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            en_q  <= 1'b0;
            cmp_q <= '0;
            cnt_q <= '0;
            tgl_q <= 1'b0;
        end else begin
            if (wr_en && offs == TMR_CTRL) en_q <= apb_i.pwdata[0];
            if (cmp_wr) cmp_q <= apb_i.pwdata[TIMER_WIDTH-1:0];

            if (cmp_wr || timer_event_o) begin
                cnt_q <= '0;
            end else if (en_q) begin
                cnt_q <= cnt_q + 1'b1;
            end

            if (timer_event_o) tgl_q <= ~tgl_q;   // Channel output
        end
    end

    always_comb begin
        apb_rsp_o = '0;
        case (offs)
            TMR_CTRL: apb_rsp_o.prdata = DATA_W'(en_q);
            TMR_CMP:  apb_rsp_o.prdata = DATA_W'(cmp_q);
            TMR_CNT:  apb_rsp_o.prdata = DATA_W'(cnt_q);
            default:  apb_rsp_o.pslverr = psel_i;
        endcase
    end

    assign timer_o = tgl_q;

    // Count never runs past the compare value, so every period ends in a match
    a_cnt_below_cmp: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        cnt_q <= cmp_q);

endmodule

/* verification/periph_subsys_stim.txt */
# test cmd host addr data expect, all hex; WR: expect=err; RD: data=err, expect=rdata
# DW: host=first served, host1 writes expect to addr+4; SP pin 0=gpio_in 1=ext; CP pin 0..3
1 WR 0 000 000000A5 0
1 WR 1 004 0000003C 0
1 WR 1 104 00001234 0
1 RD 1 000 0 000000A5
1 RD 0 004 0 0000003C
1 RD 0 104 0 00001234
1 CP 0 000 0 A5
1 CP 1 000 0 3C
2 RD 0 300 1 00000000
2 WR 0 3F0 DEADBEEF 1
2 RD 0 014 1 00000000
2 RD 1 108 0 00000000
3 DW 0 000 0000005A 000000C3
3 RD 1 000 0 0000005A
3 RD 0 004 0 000000C3
3 DW 1 000 00000011 00000022
3 RD 1 000 0 00000011
3 RD 0 004 0 00000022
4 WR 1 00C 00000004 0
4 WR 1 204 00000001 0
4 SP 0 000 00000004 0
4 WT 0 000 00000004 0
4 RD 0 008 0 00000004
4 RD 0 010 0 00000004
4 RD 1 200 0 00000001
4 CP 3 000 0 1
4 WR 0 010 00000004 0
4 WR 0 200 00000001 0
4 WT 0 000 00000002 0
4 CP 3 000 0 0
5 WR 0 104 00000004 0
5 WR 0 100 00000001 0
5 CP 2 000 0 0
5 WT 0 000 00000006 0
5 CP 2 000 0 1
5 WT 0 000 00000005 0
5 CP 2 000 0 0
5 WT 0 000 00000004 0
5 RD 1 200 0 00000002
5 WR 1 100 00000000 0
5 WR 1 200 00000002 0
5 RD 0 200 0 00000000
6 SP 1 000 00000001 0
6 SP 1 000 00000000 0
6 WT 0 000 00000002 0
6 RD 0 200 0 00000004
6 CP 3 000 0 0
6 WR 1 204 00000005 0
6 CP 3 000 0 0
6 WT 0 000 00000001 0
6 CP 3 000 0 1

/* verification/periph_subsys_tb.sv */
// Testbench for the two-host peripheral subsystem, driven by a stimulus file
// Run from the project root so the relative stim path resolves
// Inputs change on the falling edge and outputs are sampled there as well
// Single-host accesses in the file are uncontended, so each one must finish in 3 cycles
`timescale 1ns/10ps

module periph_subsys_tb import soc_bus_pkg::*; ();

    localparam int    GPIO_W        = 8;
    localparam int    DONE_WAIT     = 10;   // Cycles allowed for one access
    localparam int    UNCONTENDED_LAT = 3;
    localparam string STIM_FILE     = "verification/periph_subsys_stim.txt";

    logic              clk_i, rst_n_i;
    logic              host0_valid_i, host1_valid_i;
    bus_req_t          host0_req_i, host1_req_i;
    logic              host0_done_o, host1_done_o;
    bus_rsp_t          host0_rsp_o, host1_rsp_o;
    logic [GPIO_W-1:0] gpio_in_i, gpio_out_o, gpio_dir_o;
    logic              timer_o, ext_evt_i, irq_o;

    int unsigned cycle_limit;
    int          err_cnt, test_err_start, tests_run, tests_failed;

    periph_subsys_top u_dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    // Ends a run that stalls, limit comes from the stim file
    initial begin : watchdog
        int unsigned cycles;
        cycles = 0;
        wait (cycle_limit != 0);
        while (cycles < cycle_limit) begin
            @(posedge clk_i);
            cycles++;
        end
        $display("Timeout: the run did not end within %0d cycles", cycle_limit);
        $display("Test failed");
        $finish;
    end

    task automatic check_rsp(input string name, input bus_rsp_t got, input bus_rsp_t exp,
                             input bit with_data);
        if (got.err !== exp.err) begin
            $display("CHECK FAILED %s.err got 0x%0h expected 0x%0h", name, got.err, exp.err);
            err_cnt++;
        end
        if (with_data && got.rdata !== exp.rdata) begin
            $display("CHECK FAILED %s.rdata got 0x%08h expected 0x%08h",
                     name, got.rdata, exp.rdata);
            err_cnt++;
        end
    endtask

    task automatic check_pins(input int sel, input logic [GPIO_W-1:0] exp_val);
        logic [GPIO_W-1:0] got;
        string             name;
        bit                known;
        known = 1'b1;
        got   = '0;
        case (sel)
            0:       begin name = "gpio_out_o"; got = gpio_out_o; end
            1:       begin name = "gpio_dir_o"; got = gpio_dir_o; end
            2:       begin name = "timer_o";    got = GPIO_W'(timer_o); end
            3:       begin name = "irq_o";      got = GPIO_W'(irq_o); end
            default: known = 1'b0;
        endcase
        if (!known) begin
            $display("Pin check names an unknown pin group %0d", sel);
            err_cnt++;
        end else if (got !== exp_val) begin
            $display("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, exp_val);
            err_cnt++;
        end
    endtask

    // Latency and arbitration order
    task automatic check_num(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic drive_host(input int host, input logic valid, input bus_req_t req);
        if (host == 0) begin
            host0_valid_i = valid;
            host0_req_i   = req;
        end else begin
            host1_valid_i = valid;
            host1_req_i   = req;
        end
    endtask

    task automatic host_access(input int host, input bus_req_t req, input bus_rsp_t exp_rsp,
                               input bit with_data);
        int       lat;
        bit       got_done;
        bus_rsp_t rsp;
        lat      = 0;
        got_done = 1'b0;
        rsp      = '0;
        drive_host(host, 1'b1, req);
        while (!got_done && lat < DONE_WAIT) begin
            @(negedge clk_i);
            lat++;
            got_done = (host == 0) ? host0_done_o : host1_done_o;
            rsp      = (host == 0) ? host0_rsp_o : host1_rsp_o;
        end
        @(negedge clk_i);                         // Valid drops in the cycle after done
        drive_host(host, 1'b0, '0);
        if (!got_done) begin
            $display("Host %0d access to 0x%03h got no done pulse within %0d cycles",
                     host, req.addr, DONE_WAIT);
            err_cnt++;
        end else begin
            check_num($sformatf("host%0d_done_o latency", host), lat, UNCONTENDED_LAT);
            check_rsp($sformatf("host%0d_rsp_o", host), rsp, exp_rsp, with_data);
        end
    endtask

    // Host 0 writes d0 to addr, host 1 writes d1 to addr + 4, both in the same cycle
    task automatic dual_write(input int first, input logic [31:0] addr, input logic [31:0] d0,
                              input logic [31:0] d1);
        bit done0, done1;
        int served_first, cycles;
        done0        = 1'b0;
        done1        = 1'b0;
        served_first = -1;
        cycles       = 0;
        drive_host(0, 1'b1, '{addr: addr[ADDR_W-1:0], write: 1'b1, wdata: d0});
        drive_host(1, 1'b1, '{addr: addr[ADDR_W-1:0] + 12'd4, write: 1'b1, wdata: d1});
        while ((host0_valid_i || host1_valid_i) && cycles < 2 * DONE_WAIT) begin
            @(negedge clk_i);
            cycles++;
            if (done0) host0_valid_i = 1'b0;      // Done seen one cycle ago
            if (done1) host1_valid_i = 1'b0;
            if (host0_done_o && !done0) begin
                done0 = 1'b1;
                if (served_first < 0) served_first = 0;
                check_rsp("host0_rsp_o", host0_rsp_o, '0, 1'b0);
            end
            if (host1_done_o && !done1) begin
                done1 = 1'b1;
                if (served_first < 0) served_first = 1;
                check_rsp("host1_rsp_o", host1_rsp_o, '0, 1'b0);
            end
        end
        if (!done0 || !done1) begin
            $display("Dual write: done pulses missing, host0 %0d host1 %0d", done0, done1);
            err_cnt++;
            drive_host(0, 1'b0, '0);
            drive_host(1, 1'b0, '0);
        end else begin
            check_num("first served host", served_first, first);
        end
    endtask

    task automatic count_limit(input int fd, output int unsigned limit);
        string       line;
        int          test, host;
        logic [63:0] cmd;
        logic [31:0] addr, data, expv;
        limit = 3 + 20;                           // Reset plus some slack
        while ($fgets(line, fd) != 0) begin
            if ($sscanf(line, "%d %s %d %h %h %h", test, cmd, host, addr, data, expv) == 6) begin
                case (cmd)
                    "WR", "RD": limit += 10;
                    "DW":       limit += 20;
                    "WT":       limit += data;
                    "SP":       limit += 1;
                    default:    limit += 0;
                endcase
            end
        end
    endtask

    task automatic finish_test(input int num);
        if (err_cnt == test_err_start) begin
            $display("test %0d finished: ok", num);
        end else begin
            $display("test %0d finished: %0d errors", num, err_cnt - test_err_start);
            tests_failed++;
        end
        tests_run++;
        test_err_start = err_cnt;
    endtask

    initial begin : stimulus
        int          fd, test, host, cur_test;
        logic [63:0] cmd;
        logic [31:0] addr, data, expv;
        string       line;
        rst_n_i        = 1'b0;
        host0_valid_i  = 1'b0;
        host1_valid_i  = 1'b0;
        host0_req_i    = '0;
        host1_req_i    = '0;
        gpio_in_i      = '0;
        ext_evt_i      = 1'b0;
        cycle_limit    = 0;
        err_cnt        = 0;
        test_err_start = 0;
        tests_run      = 0;
        tests_failed   = 0;
        cur_test       = -1;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open the stimulus file %s", STIM_FILE);
            $display("Test failed");
            $finish;
        end else begin
            count_limit(fd, cycle_limit);
            $fclose(fd);
            fd = $fopen(STIM_FILE, "r");
            repeat (3) @(posedge clk_i);
            @(negedge clk_i);
            rst_n_i = 1'b1;
            while ($fgets(line, fd) != 0) begin
                if ($sscanf(line, "%d %s %d %h %h %h", test, cmd, host, addr, data, expv) != 6)
                    continue;                     // Header or blank line
                if (test != cur_test) begin
                    if (cur_test >= 0) finish_test(cur_test);
                    cur_test = test;
                end
                case (cmd)
                    "WR": host_access(host, '{addr: addr[ADDR_W-1:0], write: 1'b1, wdata: data},
                                      '{rdata: '0, err: expv[0]}, 1'b0);
                    "RD": host_access(host, '{addr: addr[ADDR_W-1:0], write: 1'b0, wdata: '0},
                                      '{rdata: expv, err: data[0]}, 1'b1);
                    "DW": dual_write(host, addr, data, expv);
                    "SP": begin
                        if (host == 0) gpio_in_i = data[GPIO_W-1:0];
                        else ext_evt_i = data[0];
                        @(negedge clk_i);
                    end
                    "WT": repeat (data) @(negedge clk_i);
                    "CP": check_pins(host, expv[GPIO_W-1:0]);
                    default: begin
                        $display("Unknown command in the stimulus file, test %0d", test);
                        err_cnt++;
                    end
                endcase
            end
            $fclose(fd);
            if (cur_test >= 0) finish_test(cur_test);
            $display("Summary: %0d tests, %0d failing, %0d errors",
                     tests_run, tests_failed, err_cnt);
            if (err_cnt == 0 && tests_run > 0) begin
                $display("Test passed");
            end else begin
                $display("Test failed");
            end
            $finish;
        end
    end

endmodule
